// ==== arena_top.f ====
verilog/arena_pkg.sv
verilog/vga_timing.sv
verilog/game_fsm.sv
verilog/obstacle_sequencer.sv
verilog/arena_painter.sv
verilog/obstacle_painter.sv
verilog/hp_tracker.sv
verilog/arena_top.sv
verification/arena_top_chk.sv
verification/arena_top_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= arena_top_tb
FILELIST  ?= arena_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_TEXT ?= TEST PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/arena_top_tb.sv ====
`timescale 1ns/1ps

module arena_top_tb;

  localparam int H_ACTIVE        = 160;
  localparam int H_FRONT         = 8;
  localparam int H_SYNC          = 16;
  localparam int H_BACK          = 16;
  localparam int V_ACTIVE        = 120;
  localparam int V_FRONT         = 2;
  localparam int V_SYNC          = 3;
  localparam int V_BACK          = 5;
  localparam int OBSTACLE_FRAMES = 4;
  localparam int HP_MAX          = 5;
  localparam int H_TOTAL         = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL         = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 10;

  typedef struct packed {
    logic              game;
    logic              menu;
    logic [3:0]        pulses;
    logic              hit;
    logic [7:0]        frames;
    arena_pkg::coord_t px;
    arena_pkg::coord_t py;
  } scenario_t;

  localparam int N_SCEN = 12;

  // game, menu, victory pulses, cursor in obstacle, frames, sampled pixel
  localparam scenario_t SCENARIOS [N_SCEN] = '{
    '{1'b0, 1'b0, 4'd0, 1'b0, 8'd1, 12'd80,  12'd65},
    '{1'b0, 1'b0, 4'd0, 1'b0, 8'd1, 12'd20,  12'd60},
    '{1'b0, 1'b0, 4'd0, 1'b0, 8'd1, 12'd10,  12'd60},
    '{1'b1, 1'b0, 4'd0, 1'b0, 8'd1, 12'd55,  12'd55},
    '{1'b0, 1'b0, 4'd0, 1'b0, 8'd4, 12'd6,   12'd5},
    '{1'b0, 1'b0, 4'd0, 1'b0, 8'd4, 12'd75,  12'd55},
    '{1'b0, 1'b0, 4'd0, 1'b1, 8'd3, 12'd14,  12'd5},
    '{1'b0, 1'b0, 4'd0, 1'b1, 8'd3, 12'd6,   12'd5},
    '{1'b0, 1'b1, 4'd0, 1'b0, 8'd1, 12'd6,   12'd5},
    '{1'b1, 1'b0, 4'd7, 1'b0, 8'd1, 12'd115, 12'd80},
    '{1'b0, 1'b0, 4'd1, 1'b0, 8'd1, 12'd55,  12'd55},
    '{1'b0, 1'b1, 4'd0, 1'b0, 8'd1, 12'd139, 12'd109}
  };

  logic                   pclk;
  logic                   reset;
  logic                   game_button;
  logic                   menu_button;
  logic                   victory_button;
  arena_pkg::cursor_t     cursor;
  logic                   hs;
  logic                   vs;
  arena_pkg::rgb_t        rgb;
  logic [15:0]            led;

  // reference model of the game
  arena_pkg::game_state_t exp_state;
  logic [3:0]             exp_code;
  int                     exp_hp;
  int                     exp_fcnt;
  arena_pkg::cursor_t     cur;

  int errors;
  int checks;
  int failed;

  arena_top #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
    .OBSTACLE_FRAMES(OBSTACLE_FRAMES), .HP_MAX(HP_MAX)
  ) dut (
    .pclk(pclk),
    .reset(reset),
    .game_button(game_button),
    .menu_button(menu_button),
    .victory_button(victory_button),
    .cursor(cursor),
    .hs(hs),
    .vs(vs),
    .rgb(rgb),
    .led(led)
  );

  initial pclk = 1'b0;
  always #(CLK_PERIOD / 2) pclk = ~pclk;

  task automatic check(input string what, input int got, input int expected);
    checks++;
    if (got != expected) begin
      errors++;
      $display("Error at %0t: %s is %0h, expected %0h", $time, what, got, expected);
    end
  endtask

  function automatic logic covers(arena_pkg::rect_t r, arena_pkg::coord_t x,
                                  arena_pkg::coord_t y);
    return (x >= r.left) && (x <= r.right) && (y >= r.top) && (y <= r.bottom);
  endfunction

  function automatic logic [11:0] expected_color(arena_pkg::coord_t x, arena_pkg::coord_t y);
    arena_pkg::rect_t  a;
    arena_pkg::coord_t b;
    logic [11:0]       c;
    a = arena_pkg::ARENA_RECT;
    b = arena_pkg::coord_t'(arena_pkg::BORDER);
    if (!covers(a, x, y)) begin
      c = arena_pkg::BG_COLOR;
    end else if ((x < a.left + b) || (x > a.right - b) || (y < a.top + b) ||
                 (y > a.bottom - b)) begin
      c = arena_pkg::BORDER_COLOR;
    end else begin
      c = arena_pkg::ARENA_COLOR;
    end
    if ((exp_state == arena_pkg::PLAY) &&
        covers(arena_pkg::OBSTACLE_TABLE[exp_code[2:0]].rect, x, y)) begin
      c = arena_pkg::OBSTACLE_TABLE[exp_code[2:0]].color;
    end
    // bar grows one step per hit point
    if ((exp_state != arena_pkg::MENU) &&
        (y >= arena_pkg::coord_t'(arena_pkg::HP_BAR_TOP)) &&
        (y < arena_pkg::coord_t'(arena_pkg::HP_BAR_TOP + arena_pkg::HP_BAR_HEIGHT)) &&
        (x >= arena_pkg::coord_t'(arena_pkg::HP_BAR_LEFT)) &&
        (x < arena_pkg::coord_t'(arena_pkg::HP_BAR_LEFT + exp_hp * arena_pkg::HP_BAR_STEP))) begin
      c = arena_pkg::HP_COLOR;
    end
    return c;
  endfunction

  task automatic advance_code();
    if (exp_code == 4'(arena_pkg::OBSTACLE_COUNT - 1)) begin
      exp_state = arena_pkg::WON;
      exp_code  = 4'd0;
      exp_hp    = HP_MAX;
    end else begin
      exp_code = exp_code + 4'd1;
    end
    exp_fcnt = 0;
  endtask

  // hit test sees the obstacle after any advance
  task automatic model_frame();
    if (exp_state == arena_pkg::PLAY) begin
      if (exp_fcnt == OBSTACLE_FRAMES - 1) begin
        advance_code();
      end else begin
        exp_fcnt++;
      end
      if ((exp_state == arena_pkg::PLAY) &&
          covers(arena_pkg::OBSTACLE_TABLE[exp_code[2:0]].rect, cur.x, cur.y)) begin
        exp_hp--;
        if (exp_hp == 0) begin
          exp_state = arena_pkg::LOST;
          exp_code  = 4'd0;
          exp_fcnt  = 0;
          exp_hp    = HP_MAX;
        end
      end
    end
  endtask

  task automatic pick_safe_cursor(output arena_pkg::cursor_t c);
    logic clash;
    clash = 1'b1;
    while (clash) begin
      c.x   = arena_pkg::coord_t'($urandom % H_ACTIVE);
      c.y   = arena_pkg::coord_t'($urandom % V_ACTIVE);
      clash = 1'b0;
      for (int k = 0; k < arena_pkg::OBSTACLE_COUNT; k++) begin
        if (covers(arena_pkg::OBSTACLE_TABLE[k].rect, c.x, c.y)) begin
          clash = 1'b1;
        end
      end
    end
  endtask

  task automatic wait_vs_fall();
    logic prev;
    logic done;
    done = 1'b0;
    while (!done) begin
      prev = vs;
      @(negedge pclk);
      done = prev && !vs;
    end
  endtask

  // follows the beam up to the next vs fall
  // position resynced on each hs fall
  task automatic scan_frame(input arena_pkg::coord_t x, input arena_pkg::coord_t y,
                            output logic [11:0] pix, output int hs_falls,
                            output int misaligned, output int blank_bad, output int vs_rises);
    int   h;
    int   v;
    logic hs_prev;
    logic vs_prev;
    logic done;
    h          = 0;
    v          = V_ACTIVE + V_FRONT;
    pix        = '0;
    hs_falls   = 0;
    misaligned = 0;
    blank_bad  = 0;
    vs_rises   = 0;
    hs_prev    = hs;
    vs_prev    = vs;
    done       = 1'b0;
    while (!done) begin
      @(negedge pclk);
      if (vs_prev && !vs) begin
        done = 1'b1;
      end else begin
        if (!vs_prev && vs) begin
          vs_rises++;
        end
        if (hs_prev && !hs) begin
          if ((hs_falls > 0) && (h + 1 != H_ACTIVE + H_FRONT)) begin
            misaligned++;
          end
          h = H_ACTIVE + H_FRONT;
          hs_falls++;
        end else begin
          h++;
          if (h == H_TOTAL) begin
            h = 0;
            v = (v + 1) % V_TOTAL;
          end
        end
        if (((h >= H_ACTIVE) || (v >= V_ACTIVE)) && (rgb != '0)) begin
          blank_bad++;
        end
        if ((h == int'(x)) && (v == int'(y))) begin
          pix = rgb;
        end
      end
      hs_prev = hs;
      vs_prev = vs;
    end
  endtask

  task automatic run_scenario(input int i);
    scenario_t         s;
    arena_pkg::rect_t  r;
    logic [11:0]       pix;
    int                hs_falls;
    int                misaligned;
    int                blank_bad;
    int                vs_rises;
    int                errs_before;
    s           = SCENARIOS[i];
    errs_before = errors;
    if (s.hit) begin
      r     = arena_pkg::OBSTACLE_TABLE[exp_code[2:0]].rect;
      cur.x = r.right - arena_pkg::coord_t'(5);
      cur.y = r.top + arena_pkg::coord_t'(5);
    end else begin
      pick_safe_cursor(cur);
    end
    @(posedge pclk);
    cursor      <= cur;
    game_button <= s.game;
    menu_button <= s.menu;
    @(posedge pclk);
    game_button <= 1'b0;
    menu_button <= 1'b0;
    // each press is held for two cycles
    repeat (s.pulses) begin
      @(posedge pclk);
      victory_button <= 1'b1;
      repeat (2) @(posedge pclk);
      victory_button <= 1'b0;
    end
    if (s.game && (exp_state == arena_pkg::MENU)) begin
      exp_state = arena_pkg::PLAY;
    end
    if (s.menu && ((exp_state == arena_pkg::LOST) || (exp_state == arena_pkg::WON))) begin
      exp_state = arena_pkg::MENU;
    end
    repeat (s.pulses) begin
      if (exp_state == arena_pkg::PLAY) begin
        advance_code();
      end
    end
    repeat (int'(s.frames) - 1) wait_vs_fall();
    scan_frame(s.px, s.py, pix, hs_falls, misaligned, blank_bad, vs_rises);
    repeat (s.frames) model_frame();
    check("state", int'(led[5:4]), int'(exp_state));
    check("obstacle code", int'(led[3:0]), int'(exp_code));
    check("hp", int'(led[11:8]), exp_hp);
    check("spare led bits", int'({led[15:12], led[7:6]}), 0);
    check($sformatf("pixel (%0d,%0d)", s.px, s.py), int'(pix),
          int'(expected_color(s.px, s.py)));
    check("hs pulses per frame", hs_falls, V_TOTAL);
    check("misplaced hs pulses", misaligned, 0);
    check("vs pulses per frame", vs_rises, 1);
    check("lit pixels in blanking", blank_bad, 0);
    if (errors != errs_before) begin
      failed++;
    end
    $display("scenario %0d %s", i, (errors == errs_before) ? "ok" : "failed");
  endtask

  function automatic int total_frames();
    int n;
    n = 2;
    for (int i = 0; i < N_SCEN; i++) begin
      n += int'(SCENARIOS[i].frames) + 1;
    end
    return n;
  endfunction

  initial begin
    longint limit;
    limit = longint'(RESET_CYCLES + total_frames() * H_TOTAL * V_TOTAL) * CLK_PERIOD;
    #(limit);
    $display("timeout: the scenarios did not finish within %0d ns", limit);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    errors         = 0;
    checks         = 0;
    failed         = 0;
    void'($urandom(68918));
    reset          = 1'b1;
    game_button    = 1'b0;
    menu_button    = 1'b0;
    victory_button = 1'b0;
    cursor         = '0;
    exp_state      = arena_pkg::MENU;
    exp_code       = 4'd0;
    exp_hp         = HP_MAX;
    exp_fcnt       = 0;
    repeat (RESET_CYCLES) @(posedge pclk);
    reset <= 1'b0;
    wait_vs_fall();
    for (int i = 0; i < N_SCEN; i++) begin
      run_scenario(i);
    end
    check("assertion failures", dut.chk.fail_count, 0);
    $display("%0d scenarios, %0d failed, %0d checks, %0d errors",
             N_SCEN, failed, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== verification/arena_top_chk.sv ====
`timescale 1ns/1ps

module arena_top_chk (
  input logic                   pclk,
  input logic                   reset,
  input arena_pkg::game_state_t state,
  input logic [3:0]             hp,
  input arena_pkg::obstacle_t   obstacle,
  input logic                   hs
);

  int fail_count = 0;

  // hp only falls while a game runs
  hp_no_rise: assert property (@(posedge pclk) disable iff (reset)
    ((state == arena_pkg::PLAY) && ($past(state) == arena_pkg::PLAY)) |-> (hp <= $past(hp)))
    else begin
      fail_count++;
      $error("hp rose during play");
    end

  menu_exit: assert property (@(posedge pclk) disable iff (reset)
    (state == arena_pkg::MENU) |=> ((state == arena_pkg::MENU) || (state == arena_pkg::PLAY)))
    else begin
      fail_count++;
      $error("menu left for a state other than play");
    end

  code_range: assert property (@(posedge pclk) disable iff (reset)
    obstacle.code < 4'(arena_pkg::OBSTACLE_COUNT))
    else begin
      fail_count++;
      $error("obstacle code out of range");
    end

  hs_in_reset: assert property (@(posedge pclk) reset |=> hs)
    else begin
      fail_count++;
      $error("hs low while in reset");
    end

endmodule

bind arena_top arena_top_chk chk (
  .pclk(pclk),
  .reset(reset),
  .state(state),
  .hp(hp),
  .obstacle(obstacle),
  .hs(hs)
);

// ==== verilog/arena_top.sv ====
`timescale 1ns/1ps

module arena_top #(
  parameter int H_ACTIVE        = 160,
  parameter int H_FRONT         = 8,
  parameter int H_SYNC          = 16,
  parameter int H_BACK          = 16,
  parameter int V_ACTIVE        = 120,
  parameter int V_FRONT         = 2,
  parameter int V_SYNC          = 3,
  parameter int V_BACK          = 5,
  parameter int OBSTACLE_FRAMES = 4,
  parameter int HP_MAX          = 5
) (
  input  logic               pclk,
  input  logic               reset,
  input  logic               game_button,
  input  logic               menu_button,
  input  logic               victory_button,
  input  arena_pkg::cursor_t cursor,
  output logic               hs,
  output logic               vs,
  output arena_pkg::rgb_t    rgb,
  output logic [15:0]        led
);

  arena_pkg::beam_t       beam;
  arena_pkg::pixel_t      pixel_arena;
  arena_pkg::pixel_t      pixel_obstacle;
  arena_pkg::pixel_t      pixel_hp;
  arena_pkg::game_state_t state;
  arena_pkg::obstacle_t   obstacle;
  logic                   victory;
  logic                   hp_empty;
  logic [3:0]             hp;

  vga_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) u_vga_timing (
    .pclk(pclk),
    .reset(reset),
    .beam(beam)
  );

  game_fsm u_game_fsm (
    .pclk(pclk),
    .reset(reset),
    .game_button(game_button),
    .menu_button(menu_button),
    .victory(victory),
    .hp_empty(hp_empty),
    .state(state)
  );

  obstacle_sequencer #(
    .OBSTACLE_FRAMES(OBSTACLE_FRAMES)
  ) u_obstacle_sequencer (
    .pclk(pclk),
    .reset(reset),
    .state(state),
    .frame_start(beam.frame_start),
    .victory_button(victory_button),
    .obstacle(obstacle),
    .victory(victory)
  );

  arena_painter u_arena_painter (
    .pclk(pclk),
    .reset(reset),
    .beam(beam),
    .pixel(pixel_arena)
  );

  obstacle_painter u_obstacle_painter (
    .pclk(pclk),
    .reset(reset),
    .pixel_in(pixel_arena),
    .obstacle(obstacle),
    .active(state == arena_pkg::PLAY),
    .pixel(pixel_obstacle)
  );

  hp_tracker #(
    .HP_MAX(HP_MAX)
  ) u_hp_tracker (
    .pclk(pclk),
    .reset(reset),
    .pixel_in(pixel_obstacle),
    .state(state),
    .obstacle(obstacle),
    .cursor(cursor),
    .pixel(pixel_hp),
    .hp(hp),
    .hp_empty(hp_empty)
  );

  // three pixel stages behind the counters
  assign hs  = pixel_hp.beam.hsync;
  assign vs  = pixel_hp.beam.vsync;
  assign rgb = pixel_hp.color.rgb;

  assign led = {4'b0000, hp, 2'b00, state, obstacle.code};

endmodule

// ==== verilog/hp_tracker.sv ====
`timescale 1ns/1ps

module hp_tracker #(
  parameter int HP_MAX = 5
) (
  input  logic                   pclk,
  input  logic                   reset,
  input  arena_pkg::pixel_t      pixel_in,
  input  arena_pkg::game_state_t state,
  input  arena_pkg::obstacle_t   obstacle,
  input  arena_pkg::cursor_t     cursor,
  output arena_pkg::pixel_t      pixel,
  output logic [3:0]             hp,
  output logic                   hp_empty
);

  logic              hit;
  logic              blank;
  logic              in_bar;
  arena_pkg::coord_t bar_end;

  assign hit = arena_pkg::in_rect(obstacle.rect, cursor.x, cursor.y);

  // one hit point per frame while the cursor sits in the obstacle
  always_ff @(posedge pclk) begin
    if (reset) begin
      hp <= 4'(HP_MAX);
    end else if (state != arena_pkg::PLAY) begin
      hp <= 4'(HP_MAX);
    end else if (pixel_in.beam.frame_start && hit && (hp != '0)) begin
      hp <= hp - 1'b1;
    end
  end

  assign hp_empty = hp == '0;

  assign blank   = pixel_in.beam.hblnk || pixel_in.beam.vblnk;
  assign bar_end = arena_pkg::coord_t'(arena_pkg::HP_BAR_LEFT) +
                   arena_pkg::coord_t'(hp) * arena_pkg::coord_t'(arena_pkg::HP_BAR_STEP);
  assign in_bar  = (state != arena_pkg::MENU) && !blank &&
                   (pixel_in.beam.vcount >= arena_pkg::coord_t'(arena_pkg::HP_BAR_TOP)) &&
                   (pixel_in.beam.vcount < arena_pkg::coord_t'(arena_pkg::HP_BAR_TOP +
                                                               arena_pkg::HP_BAR_HEIGHT)) &&
                   (pixel_in.beam.hcount >= arena_pkg::coord_t'(arena_pkg::HP_BAR_LEFT)) &&
                   (pixel_in.beam.hcount < bar_end);

  always_ff @(posedge pclk) begin
    if (reset) begin
      pixel <= arena_pkg::PIXEL_IDLE;
    end else begin
      pixel.beam <= pixel_in.beam;
      if (in_bar) begin
        pixel.color.raw <= arena_pkg::HP_COLOR;
      end else begin
        pixel.color <= pixel_in.color;
      end
    end
  end

endmodule

// ==== verilog/obstacle_painter.sv ====
`timescale 1ns/1ps

module obstacle_painter (
  input  logic                 pclk,
  input  logic                 reset,
  input  arena_pkg::pixel_t    pixel_in,
  input  arena_pkg::obstacle_t obstacle,
  input  logic                 active,
  output arena_pkg::pixel_t    pixel
);

  logic blank;
  logic in_obstacle;
  logic paint;

  assign blank       = pixel_in.beam.hblnk || pixel_in.beam.vblnk;
  assign in_obstacle = arena_pkg::in_rect(obstacle.rect, pixel_in.beam.hcount,
                                          pixel_in.beam.vcount);
  assign paint       = active && !blank && in_obstacle;

  always_ff @(posedge pclk) begin
    if (reset) begin
      pixel <= arena_pkg::PIXEL_IDLE;
    end else begin
      pixel.beam <= pixel_in.beam;
      // obstacle replaces whatever the arena stage drew
      if (paint) begin
        pixel.color <= obstacle.color;
      end else begin
        pixel.color <= pixel_in.color;
      end
    end
  end

endmodule

// ==== verilog/arena_painter.sv ====
`timescale 1ns/1ps

module arena_painter (
  input  logic              pclk,
  input  logic              reset,
  input  arena_pkg::beam_t  beam,
  output arena_pkg::pixel_t pixel
);

  // arena minus its border
  localparam arena_pkg::rect_t INNER_RECT = '{
    arena_pkg::coord_t'(arena_pkg::ARENA_RECT.left + arena_pkg::BORDER),
    arena_pkg::coord_t'(arena_pkg::ARENA_RECT.right - arena_pkg::BORDER),
    arena_pkg::coord_t'(arena_pkg::ARENA_RECT.top + arena_pkg::BORDER),
    arena_pkg::coord_t'(arena_pkg::ARENA_RECT.bottom - arena_pkg::BORDER)
  };

  logic             blank;
  logic             in_arena;
  logic             in_inner;
  arena_pkg::color_u color;

  assign blank    = beam.hblnk || beam.vblnk;
  assign in_arena = arena_pkg::in_rect(arena_pkg::ARENA_RECT, beam.hcount, beam.vcount);
  assign in_inner = arena_pkg::in_rect(INNER_RECT, beam.hcount, beam.vcount);

  always_comb begin
    if (blank) begin
      color.raw = 12'h000;
    end else if (!in_arena) begin
      color.raw = arena_pkg::BG_COLOR;
    end else if (!in_inner) begin
      color.raw = arena_pkg::BORDER_COLOR;
    end else begin
      color.raw = arena_pkg::ARENA_COLOR;
    end
  end

  always_ff @(posedge pclk) begin
    if (reset) begin
      pixel <= arena_pkg::PIXEL_IDLE;
    end else begin
      pixel.beam  <= beam;
      pixel.color <= color;
    end
  end

endmodule

// ==== verilog/obstacle_sequencer.sv ====
`timescale 1ns/1ps

module obstacle_sequencer #(
  parameter int OBSTACLE_FRAMES = 4
) (
  input  logic                   pclk,
  input  logic                   reset,
  input  arena_pkg::game_state_t state,
  input  logic                   frame_start,
  input  logic                   victory_button,
  output arena_pkg::obstacle_t   obstacle,
  output logic                   victory
);

  localparam int CNT_W = $clog2(OBSTACLE_FRAMES + 1);
  localparam int IDX_W = $clog2(arena_pkg::OBSTACLE_COUNT);

  logic [CNT_W-1:0]        frame_cnt;
  logic [3:0]              code;
  logic                    button_q;
  logic                    button_rise;
  logic                    frames_done;
  logic                    playing;
  logic                    advance;
  logic                    last;
  arena_pkg::table_entry_t entry;

  assign playing     = state == arena_pkg::PLAY;
  assign button_rise = victory_button && !button_q;
  assign frames_done = frame_start && (frame_cnt == CNT_W'(OBSTACLE_FRAMES - 1));
  assign advance     = playing && (button_rise || frames_done);
  assign last        = code == 4'(arena_pkg::OBSTACLE_COUNT - 1);

  always_ff @(posedge pclk) begin
    if (reset) begin
      frame_cnt <= '0;
      code      <= '0;
      button_q  <= 1'b0;
      victory   <= 1'b0;
    end else begin
      button_q <= victory_button;
      // advancing past the last obstacle wins instead of wrapping
      victory  <= advance && last;
      if (!playing) begin
        frame_cnt <= '0;
        code      <= '0;
      end else if (advance) begin
        frame_cnt <= '0;
        if (!last) begin
          code <= code + 1'b1;
        end
      end else if (frame_start) begin
        frame_cnt <= frame_cnt + 1'b1;
      end
    end
  end

  assign entry = arena_pkg::OBSTACLE_TABLE[code[IDX_W-1:0]];

  always_comb begin
    obstacle.code      = code;
    obstacle.rect      = entry.rect;
    obstacle.color.raw = entry.color;
  end

endmodule

// ==== verilog/game_fsm.sv ====
`timescale 1ns/1ps

module game_fsm (
  input  logic                   pclk,
  input  logic                   reset,
  input  logic                   game_button,
  input  logic                   menu_button,
  input  logic                   victory,
  input  logic                   hp_empty,
  output arena_pkg::game_state_t state
);

  arena_pkg::game_state_t state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      arena_pkg::MENU: begin
        if (game_button) begin
          state_nxt = arena_pkg::PLAY;
        end
      end
      arena_pkg::PLAY: begin
        // losing takes priority over a same-cycle victory
        if (hp_empty) begin
          state_nxt = arena_pkg::LOST;
        end else if (victory) begin
          state_nxt = arena_pkg::WON;
        end
      end
      arena_pkg::LOST, arena_pkg::WON: begin
        if (menu_button) begin
          state_nxt = arena_pkg::MENU;
        end
      end
      default: begin
        state_nxt = arena_pkg::MENU;
      end
    endcase
  end

  always_ff @(posedge pclk) begin
    if (reset) begin
      state <= arena_pkg::MENU;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

// ==== verilog/vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing #(
  parameter int H_ACTIVE = 160,
  parameter int H_FRONT  = 8,
  parameter int H_SYNC   = 16,
  parameter int H_BACK   = 16,
  parameter int V_ACTIVE = 120,
  parameter int V_FRONT  = 2,
  parameter int V_SYNC   = 3,
  parameter int V_BACK   = 5
) (
  input  logic             pclk,
  input  logic             reset,
  output arena_pkg::beam_t beam
);

  localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
  localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

  arena_pkg::coord_t hcount;
  arena_pkg::coord_t vcount;
  logic              line_end;
  logic              frame_end;

  assign line_end  = hcount == arena_pkg::coord_t'(H_TOTAL - 1);
  assign frame_end = vcount == arena_pkg::coord_t'(V_TOTAL - 1);

  always_ff @(posedge pclk) begin
    if (reset) begin
      hcount <= '0;
      vcount <= '0;
    end else if (line_end) begin
      hcount <= '0;
      vcount <= frame_end ? '0 : vcount + 1'b1;
    end else begin
      hcount <= hcount + 1'b1;
    end
  end

  // sync pulses active low
  always_comb begin
    beam.hcount      = hcount;
    beam.vcount      = vcount;
    beam.hsync       = !((hcount >= arena_pkg::coord_t'(H_SYNC_START)) &&
                         (hcount < arena_pkg::coord_t'(H_SYNC_START + H_SYNC)));
    beam.vsync       = !((vcount >= arena_pkg::coord_t'(V_SYNC_START)) &&
                         (vcount < arena_pkg::coord_t'(V_SYNC_START + V_SYNC)));
    beam.hblnk       = hcount >= arena_pkg::coord_t'(H_ACTIVE);
    beam.vblnk       = vcount >= arena_pkg::coord_t'(V_ACTIVE);
    beam.frame_start = (hcount == '0) && (vcount == '0);
  end

endmodule

// ==== verilog/arena_pkg.sv ====
package arena_pkg;

  typedef logic [11:0] coord_t;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  // table keeps raw words, painters and output look at channels
  typedef union packed {
    logic [11:0] raw;
    rgb_t        rgb;
  } color_u;

  typedef struct packed {
    coord_t hcount;
    coord_t vcount;
    logic   hsync;
    logic   vsync;
    logic   hblnk;
    logic   vblnk;
    logic   frame_start;
  } beam_t;

  typedef struct packed {
    beam_t  beam;
    color_u color;
  } pixel_t;

  typedef struct packed {
    coord_t left;
    coord_t right;
    coord_t top;
    coord_t bottom;
  } rect_t;

  typedef struct packed {
    logic [3:0] code;
    rect_t      rect;
    color_u     color;
  } obstacle_t;

  typedef enum logic [1:0] {
    MENU = 2'd0,
    PLAY = 2'd1,
    LOST = 2'd2,
    WON  = 2'd3
  } game_state_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
  } cursor_t;

  typedef struct packed {
    rect_t       rect;
    logic [11:0] color;
  } table_entry_t;

  localparam int OBSTACLE_COUNT = 8;

  // overlapping on purpose, only the current code matters
  localparam table_entry_t OBSTACLE_TABLE [OBSTACLE_COUNT] = '{
    '{'{12'd40,  12'd70,  12'd40, 12'd70}, 12'hf00},
    '{'{12'd60,  12'd90,  12'd40, 12'd70}, 12'h00f},
    '{'{12'd80,  12'd110, 12'd40, 12'd70}, 12'hff0},
    '{'{12'd100, 12'd130, 12'd40, 12'd70}, 12'h0ff},
    '{'{12'd40,  12'd70,  12'd60, 12'd95}, 12'hf0f},
    '{'{12'd60,  12'd90,  12'd60, 12'd95}, 12'hf80},
    '{'{12'd80,  12'd110, 12'd60, 12'd95}, 12'h80f},
    '{'{12'd100, 12'd130, 12'd60, 12'd95}, 12'h08f}
  };

  localparam rect_t ARENA_RECT = '{12'd20, 12'd139, 12'd20, 12'd109};
  localparam int BORDER = 3;

  localparam logic [11:0] BG_COLOR     = 12'h000;
  localparam logic [11:0] ARENA_COLOR  = 12'h333;
  localparam logic [11:0] BORDER_COLOR = 12'hfff;
  localparam logic [11:0] HP_COLOR     = 12'h0f0;

  // hp bar sits in rows 4..7
  localparam int HP_BAR_TOP    = 4;
  localparam int HP_BAR_HEIGHT = 4;
  localparam int HP_BAR_LEFT   = 4;
  localparam int HP_BAR_STEP   = 4;

  localparam pixel_t PIXEL_IDLE = '{
    beam: '{hcount: 12'd0, vcount: 12'd0, hsync: 1'b1, vsync: 1'b1,
            hblnk: 1'b0, vblnk: 1'b0, frame_start: 1'b0},
    color: 12'h000
  };

  // bounds inclusive
  function automatic logic in_rect(rect_t r, coord_t x, coord_t y);
    return (x >= r.left) && (x <= r.right) && (y >= r.top) && (y <= r.bottom);
  endfunction

endpackage
